// ==== tb.f ====
source/simd_alu_pkg.sv
source/alu_op_decoder.sv
source/alu_lane.sv
source/result_collector.sv
source/simd_alu_top.sv
verification/alu_checker.sv
verification/tb_top.sv

// ==== verification/tb_top.sv ====
/*
 * tb_top: clock, reset and seeded random instruction stream for the SIMD ALU
 */
`timescale 1ns/1ps

module tb_top import simd_alu_pkg::*; ();

	// cycles allowed for the pipeline to empty after a test
	localparam int DRAIN_LIMIT = 20;

	logic       clk;
	logic       rst;
	logic       in_valid;
	op_class_t  op_class;
	logic [2:0] funct3;
	logic       funct7_5;
	wide_word_t src1_vec;
	wide_word_t src2_vec;
	logic       out_valid;
	logic       out_error;
	wide_word_t result_vec;
	lane_mask_t zero_mask;
	logic       all_zero;
	int         test_id;
	logic       test_done;
	int         pending;
	int         errors;
	int         checks;
	int         stuck;
	int         seed;

	always #10 clk = ~clk;

	simd_alu_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.op_class   (op_class),
		.funct3     (funct3),
		.funct7_5   (funct7_5),
		.src1_vec   (src1_vec),
		.src2_vec   (src2_vec),
		.out_valid  (out_valid),
		.out_error  (out_error),
		.result_vec (result_vec),
		.zero_mask  (zero_mask),
		.all_zero   (all_zero)
	);

	alu_checker u_chk (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.op_class   (op_class),
		.funct3     (funct3),
		.funct7_5   (funct7_5),
		.src1_vec   (src1_vec),
		.src2_vec   (src2_vec),
		.out_valid  (out_valid),
		.out_error  (out_error),
		.result_vec (result_vec),
		.zero_mask  (zero_mask),
		.all_zero   (all_zero),
		.test_id    (test_id),
		.test_done  (test_done),
		.pending    (pending),
		.errors     (errors),
		.checks     (checks)
	);

	function automatic wide_word_t rand_vec();
		wide_word_t v;
		for (int i = 0; i < LANES; i++) begin
			v[i*WORD_W +: WORD_W] = $urandom();
		end
		return v;
	endfunction

	// one strobe, left high so strobes run back to back
	task automatic issue(input op_class_t cls, input logic [2:0] f3, input logic f7,
			input wide_word_t a, input wide_word_t b);
		@(posedge clk);
		in_valid <= 1'b1;
		op_class <= cls;
		funct3 <= f3;
		funct7_5 <= f7;
		src1_vec <= a;
		src2_vec <= b;
	endtask

	task automatic start_test(input int id);
		@(posedge clk);
		in_valid <= 1'b0;
		test_id <= id;
	endtask

	// let the pipeline empty, then have the checker report the test
	task automatic close_test();
		int n;
		@(posedge clk);
		in_valid <= 1'b0;
		n = 0;
		while (pending != 0 && n < DRAIN_LIMIT) begin
			@(posedge clk);
			n = n + 1;
		end
		if (pending != 0) begin
			$display("Timeout: %0d results still outstanding at the end of test %0d",
				pending, test_id);
			stuck = stuck + 1;
		end
		@(posedge clk);
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
	endtask

	initial begin
		logic [2:0] f3;
		wide_word_t a;
		wide_word_t b;
		seed = $urandom(27);
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		op_class = CLS_REG;
		funct3 = 3'd0;
		funct7_5 = 1'b0;
		src1_vec = '0;
		src2_vec = '0;
		test_id = 0;
		test_done = 1'b0;
		stuck = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// add, sub, xor, or, and
		start_test(1);
		for (int k = 0; k < 40; k++) begin
			case ($urandom() % 4)
				0: f3 = 3'd0;
				1: f3 = 3'd4;
				2: f3 = 3'd6;
				default: f3 = 3'd7;
			endcase
			issue(CLS_REG, f3, 1'($urandom() % 2), rand_vec(), rand_vec());
		end
		close_test();

		start_test(2);
		for (int k = 0; k < 16; k++) begin
			issue(CLS_REG, 3'd2 + 3'($urandom() % 2), 1'b0, rand_vec(), rand_vec());
		end
		// edge pairs, most negative vs 1, equal, all ones vs 1, all ones vs all ones
		for (int i = 0; i < LANES; i++) begin
			case (i % 4)
				0: begin
					a[i*WORD_W +: WORD_W] = 32'h8000_0000;
					b[i*WORD_W +: WORD_W] = 32'd1;
				end
				1: begin
					a[i*WORD_W +: WORD_W] = $urandom();
					b[i*WORD_W +: WORD_W] = a[i*WORD_W +: WORD_W];
				end
				2: begin
					a[i*WORD_W +: WORD_W] = '1;
					b[i*WORD_W +: WORD_W] = 32'd1;
				end
				default: begin
					a[i*WORD_W +: WORD_W] = '1;
					b[i*WORD_W +: WORD_W] = '1;
				end
			endcase
		end
		issue(CLS_REG, 3'd2, 1'b0, a, b);
		issue(CLS_REG, 3'd3, 1'b0, a, b);
		issue(CLS_IMM, 3'd2, 1'b0, b, a);
		issue(CLS_IMM, 3'd3, 1'b0, b, a);
		close_test();

		// full 32-bit src2, only its low 5 bits may count
		start_test(3);
		for (int k = 0; k < 30; k++) begin
			issue(CLS_IMM, ($urandom() % 2) ? 3'd1 : 3'd5, 1'($urandom() % 2),
				rand_vec(), rand_vec());
		end
		close_test();

		start_test(4);
		for (int k = 0; k < 10; k++) begin
			issue(CLS_LUI, 3'($urandom() % 8), 1'($urandom() % 2), rand_vec(), rand_vec());
			issue(CLS_IMM, 3'd0, 1'b1, rand_vec(), rand_vec());
		end
		close_test();

		// sub of equal operands zeroes exactly the lanes picked by k
		start_test(5);
		for (int k = 0; k < 16; k++) begin
			a = rand_vec();
			for (int i = 0; i < LANES; i++) begin
				b[i*WORD_W +: WORD_W] = ((k >> (i % 4)) & 1) ? a[i*WORD_W +: WORD_W]
					: a[i*WORD_W +: WORD_W] ^ ($urandom() | 32'd1);
			end
			issue(CLS_REG, 3'd0, 1'b1, a, b);
		end
		close_test();

		// illegal class mixed in between valid neighbors
		start_test(6);
		issue(CLS_REG, 3'd0, 1'b0, rand_vec(), rand_vec());
		issue(2'd3, 3'd0, 1'b0, rand_vec(), rand_vec());
		issue(CLS_IMM, 3'd6, 1'b0, rand_vec(), rand_vec());
		issue(2'd3, 3'd5, 1'b1, rand_vec(), rand_vec());
		issue(2'd3, 3'd7, 1'b0, rand_vec(), rand_vec());
		issue(CLS_REG, 3'd5, 1'b1, rand_vec(), rand_vec());
		for (int k = 0; k < 24; k++) begin
			issue(op_class_t'($urandom() % 4), 3'($urandom() % 8), 1'($urandom() % 2),
				rand_vec(), rand_vec());
		end
		close_test();

		$display("total: %0d checks, %0d errors, %0d drain timeouts", checks, errors, stuck);
		if (errors == 0 && stuck == 0 && checks > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/alu_checker.sv ====
/*
 * alu_checker: reference model of the SIMD ALU, queues the expected vector on
 * each accepted strobe and compares it with the DUT outputs three cycles later
 */
`timescale 1ns/1ps

module alu_checker import simd_alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  op_class_t  op_class,
	input  logic [2:0] funct3,
	input  logic       funct7_5,
	input  wide_word_t src1_vec,
	input  wide_word_t src2_vec,
	input  logic       out_valid,
	input  logic       out_error,
	input  wide_word_t result_vec,
	input  lane_mask_t zero_mask,
	input  logic       all_zero,
	input  int         test_id,
	input  logic       test_done,
	output int         pending,
	output int         errors,
	output int         checks
);

	// strobe to output, counted in sampled cycles
	localparam int LATENCY = 3;

	// one entry per accepted strobe, oldest first
	logic       q_err[$];
	wide_word_t q_res[$];
	int         q_test[$];
	int         q_cyc[$];
	int         cyc;
	int         base_checks;
	int         base_errors;

	function automatic string test_name(input int id);
		case (id)
			1: test_name = "reg_arith_logic";
			2: test_name = "slt_sltu";
			3: test_name = "imm_shifts";
			4: test_name = "lui_addi";
			5: test_name = "zero_mask";
			6: test_name = "illegal_class";
			default: test_name = "idle";
		endcase
	endfunction

	// RV32I result of one lane
	function automatic word_t lane_model(input op_class_t cls, input logic [2:0] f3,
			input logic f7, input word_t a, input word_t b);
		word_t r;
		case (f3)
			// sub only in register form
			3'd0: r = (cls == CLS_REG && f7) ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (f7) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		// lui takes the immediate as it is
		if (cls == CLS_LUI) r = b;
		lane_model = r;
	endfunction

	task automatic expect_eq(input int tid, input string field, input wide_word_t exp,
			input wide_word_t act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected %0h, actual %0h",
				test_name(tid), field, exp, act);
			errors = errors + 1;
		end
	endtask

	// negedge sampling, inputs and outputs are settled here
	always @(negedge clk) begin : sample
		logic       e_err;
		wide_word_t e_res;
		wide_word_t m_res;
		lane_mask_t e_zero;
		int         e_test;
		int         e_cyc;
		if (rst) begin
			cyc = 0;
			errors = 0;
			checks = 0;
			base_checks = 0;
			base_errors = 0;
			pending = 0;
		end else begin
			cyc = cyc + 1;
			if (in_valid) begin
				for (int i = 0; i < LANES; i++) begin
					m_res[i*WORD_W +: WORD_W] = lane_model(op_class, funct3, funct7_5,
						src1_vec[i*WORD_W +: WORD_W], src2_vec[i*WORD_W +: WORD_W]);
				end
				// an illegal class leaves the result bus at zero
				q_err.push_back(op_class == 2'd3);
				q_res.push_back((op_class == 2'd3) ? '0 : m_res);
				q_test.push_back(test_id);
				q_cyc.push_back(cyc);
			end
			if (out_valid || out_error) begin
				if (q_err.size() == 0) begin
					$display("Output appeared in test %s with no instruction outstanding",
						test_name(test_id));
					errors = errors + 1;
				end else begin
					e_err = q_err.pop_front();
					e_res = q_res.pop_front();
					e_test = q_test.pop_front();
					e_cyc = q_cyc.pop_front();
					checks = checks + 1;
					for (int i = 0; i < LANES; i++) begin
						e_zero[i] = !e_err && (e_res[i*WORD_W +: WORD_W] == '0);
					end
					if (cyc - e_cyc != LATENCY) begin
						$display("Wrong latency in test %s: output after %0d cycles",
							test_name(e_test), cyc - e_cyc);
						errors = errors + 1;
					end
					expect_eq(e_test, "out_valid", !e_err, out_valid);
					expect_eq(e_test, "out_error", e_err, out_error);
					expect_eq(e_test, "result_vec", e_res, result_vec);
					expect_eq(e_test, "zero_mask", e_zero, zero_mask);
					expect_eq(e_test, "all_zero", !e_err && (&e_zero), all_zero);
				end
			end else begin
				// no vector out, flags stay low
				expect_eq(test_id, "idle zero_mask", '0, zero_mask);
				expect_eq(test_id, "idle all_zero", '0, all_zero);
			end
			// head entry is due now, nothing came
			if (q_cyc.size() > 0 && cyc - q_cyc[0] >= LATENCY) begin
				$display("Timeout in test %s: no output %0d cycles after the strobe",
					test_name(q_test[0]), LATENCY);
				errors = errors + 1;
				e_err = q_err.pop_front();
				e_res = q_res.pop_front();
				e_test = q_test.pop_front();
				e_cyc = q_cyc.pop_front();
			end
			if (test_done) begin
				$display("test %s done: %0d checks, %0d errors", test_name(test_id),
					checks - base_checks, errors - base_errors);
				base_checks = checks;
				base_errors = errors;
			end
			pending = q_err.size();
		end
	end

endmodule

// ==== source/simd_alu_top.sv ====
/*
 * simd_alu_top: four-lane SIMD integer ALU, decode, lane compute and
 * collect stages, three cycles from strobe to result
 */
`timescale 1ns/1ps

module simd_alu_top import simd_alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  op_class_t  op_class,
	input  logic [2:0] funct3,
	input  logic       funct7_5,
	input  wide_word_t src1_vec,
	input  wide_word_t src2_vec,
	output logic       out_valid,
	output logic       out_error,
	output wide_word_t result_vec,
	output lane_mask_t zero_mask,
	output logic       all_zero
);

	alu_ctrl_t  ctrl;
	logic       dec_valid;
	logic       dec_error;
	wide_word_t op1_vec;
	wide_word_t op2_vec;
	wide_word_t lane_result;
	lane_mask_t lane_valid;
	// error pulse delayed to match the lane stage
	logic       err_q;

	// stage 1, decode
	alu_op_decoder u_dec (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op_class  (op_class),
		.funct3    (funct3),
		.funct7_5  (funct7_5),
		.src1_vec  (src1_vec),
		.src2_vec  (src2_vec),
		.ctrl      (ctrl),
		.dec_valid (dec_valid),
		.dec_error (dec_error),
		.op1_vec   (op1_vec),
		.op2_vec   (op2_vec)
	);

	// stage 2, one lane per word, ctrl broadcast to all
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		alu_lane u_lane (
			.clk          (clk),
			.rst          (rst),
			.ctrl         (ctrl),
			.in_valid     (dec_valid),
			.src1         (op1_vec[i*WORD_W +: WORD_W]),
			.src2         (op2_vec[i*WORD_W +: WORD_W]),
			.result       (lane_result[i*WORD_W +: WORD_W]),
			.result_valid (lane_valid[i])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			err_q <= 1'b0;
		end else begin
			err_q <= dec_error;
		end
	end

	// stage 3, pack and flag
	result_collector u_col (
		.clk         (clk),
		.rst         (rst),
		.lane_result (lane_result),
		.lane_valid  (lane_valid),
		.err_in      (err_q),
		.result_vec  (result_vec),
		.zero_mask   (zero_mask),
		.all_zero    (all_zero),
		.out_valid   (out_valid),
		.out_error   (out_error)
	);

endmodule

// ==== source/result_collector.sv ====
/*
 * result_collector: final stage, registers packed lane results with a
 * per-lane zero mask, an all-zero flag and the output valid and error
 */
`timescale 1ns/1ps

module result_collector import simd_alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  wide_word_t lane_result,
	input  lane_mask_t lane_valid,
	input  logic       err_in,
	output wide_word_t result_vec,
	output lane_mask_t zero_mask,
	output logic       all_zero,
	output logic       out_valid,
	output logic       out_error
);

	lane_mask_t lane_zero;
	logic       all_valid;

	// the whole vector is valid only when every lane is
	assign all_valid = &lane_valid;

	// per-lane zero detect
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_zero[i] = (lane_result[i*WORD_W +: WORD_W] == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_error <= 1'b0;
			zero_mask <= '0;
			all_zero  <= 1'b0;
		end else begin
			out_valid <= all_valid;
			out_error <= err_in;
			// flags only mean something for a valid vector
			zero_mask <= all_valid ? lane_zero : '0;
			all_zero  <= all_valid & (&lane_zero);
		end
	end

	// results read as zero when no valid vector arrived, e.g. after an error
	always_ff @(posedge clk) begin
		result_vec <= all_valid ? lane_result : '0;
	end

	// lanes share one control path so they must move in lockstep
	a_lanes_lockstep: assert property (
		@(posedge clk) disable iff (rst) (lane_valid == '0) || (lane_valid == '1)
	);

endmodule

// ==== source/alu_lane.sv ====
/*
 * alu_lane: one SIMD lane, computes the selected RV32I integer operation
 * on its operand pair and registers the result with a valid flag
 */
`timescale 1ns/1ps

module alu_lane import simd_alu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  alu_ctrl_t ctrl,
	input  logic      in_valid,
	input  word_t     src1,
	input  word_t     src2,
	output word_t     result,
	output logic      result_valid
);

	word_t              diff;
	logic               no_borrow;
	logic               ovf;
	logic               lt_signed;
	logic               lt_unsigned;
	logic [SHAMT_W-1:0] shamt;
	word_t              alu_out;

	// src1 - src2 as src1 + ~src2 + 1, top bit is the carry out
	assign {no_borrow, diff} = {1'b0, src1} + {1'b0, ~src2} + (WORD_W+1)'(1);

	// overflow when the signs differ and the difference flips away from src1
	assign ovf = (src1[WORD_W-1] ^ src2[WORD_W-1]) & (src1[WORD_W-1] ^ diff[WORD_W-1]);

	// signed less-than, sign of difference corrected for overflow
	assign lt_signed = diff[WORD_W-1] ^ ovf;

	// unsigned less-than, a borrow means src1 < src2
	assign lt_unsigned = ~no_borrow;

	// only the low 5 bits of src2 count for shifts
	assign shamt = src2[SHAMT_W-1:0];

	always_comb begin
		case (ctrl)
			ALU_ADD:  alu_out = src1 + src2;
			ALU_SUB:  alu_out = diff;
			ALU_SLT:  alu_out = {{(WORD_W-1){1'b0}}, lt_signed};
			ALU_SLTU: alu_out = {{(WORD_W-1){1'b0}}, lt_unsigned};
			ALU_XOR:  alu_out = src1 ^ src2;
			ALU_OR:   alu_out = src1 | src2;
			ALU_AND:  alu_out = src1 & src2;
			// lui, immediate already placed in src2
			ALU_PASS: alu_out = src2;
			ALU_SRL:  alu_out = src1 >> shamt;
			ALU_SLL:  alu_out = src1 << shamt;
			// fill with sign bit
			ALU_SRA:  alu_out = word_t'($signed(src1) >>> shamt);
			// codes outside the set give zero
			default:  alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= in_valid;
		end
	end

	// result word is payload, only read while valid
	always_ff @(posedge clk) begin
		result <= alu_out;
	end

	// compare ops issued last cycle come out as a single flag bit
	property p_cmp_is_flag;
		@(posedge clk) disable iff (rst)
		result_valid && ($past(ctrl) == ALU_SLT || $past(ctrl) == ALU_SLTU)
			|-> (result[WORD_W-1:1] == '0);
	endproperty

	a_cmp_is_flag: assert property (p_cmp_is_flag);

endmodule

// ==== source/alu_op_decoder.sv ====
/*
 * alu_op_decoder: maps operand class, funct3 and funct7 bit 5 onto the
 * ALU control code and registers it together with the operand vectors
 */
`timescale 1ns/1ps

module alu_op_decoder import simd_alu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  op_class_t  op_class,
	input  logic [2:0] funct3,
	input  logic       funct7_5,
	input  wide_word_t src1_vec,
	input  wide_word_t src2_vec,
	output alu_ctrl_t  ctrl,
	output logic       dec_valid,
	output logic       dec_error,
	output wide_word_t op1_vec,
	output wide_word_t op2_vec
);

	alu_ctrl_t ctrl_next;
	logic      cls_bad;

	// class 3 has no meaning
	assign cls_bad = (op_class == 2'd3);

	always_comb begin
		ctrl_next = ALU_ADD;
		if (op_class == CLS_LUI) begin
			ctrl_next = ALU_PASS;
		end else begin
			case (funct3)
				// sub exists only in register form, addi ignores funct7
				3'd0: ctrl_next = (op_class == CLS_REG && funct7_5) ? ALU_SUB : ALU_ADD;
				3'd1: ctrl_next = ALU_SLL;
				3'd2: ctrl_next = ALU_SLT;
				3'd3: ctrl_next = ALU_SLTU;
				3'd4: ctrl_next = ALU_XOR;
				// funct7 bit 5 picks arithmetic shift
				3'd5: ctrl_next = funct7_5 ? ALU_SRA : ALU_SRL;
				3'd6: ctrl_next = ALU_OR;
				3'd7: ctrl_next = ALU_AND;
				default: ctrl_next = ALU_ADD;
			endcase
		end
	end

	// control state, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl      <= ALU_ADD;
			dec_valid <= 1'b0;
			dec_error <= 1'b0;
		end else begin
			ctrl      <= ctrl_next;
			dec_valid <= in_valid & ~cls_bad;
			dec_error <= in_valid & cls_bad;
		end
	end

	// operands ride along so they line up with ctrl at the lanes
	always_ff @(posedge clk) begin
		op1_vec <= src1_vec;
		op2_vec <= src2_vec;
	end

	// an illegal instruction must never also look like a valid one
	a_valid_error_excl: assert property (
		@(posedge clk) disable iff (rst) !(dec_valid && dec_error)
	);

endmodule

// ==== source/simd_alu_pkg.sv ====
/*
 * simd_alu_pkg: shared widths, types and encodings for the four-lane SIMD ALU
 */
package simd_alu_pkg;

	// lane count, any positive value works
	localparam int LANES   = 4;
	// datapath width per lane
	localparam int WORD_W  = 32;
	// shift amount uses the low bits of src2
	localparam int SHAMT_W = $clog2(WORD_W);
	localparam int CTRL_W  = 4;

	typedef logic [WORD_W-1:0]       word_t;
	typedef logic [CTRL_W-1:0]       alu_ctrl_t;
	typedef logic [1:0]              op_class_t;
	typedef logic [LANES-1:0]        lane_mask_t;
	// lane 0 sits in the low bits
	typedef logic [LANES*WORD_W-1:0] wide_word_t;

	// alu control codes, same encoding as the scalar execute ALU
	localparam alu_ctrl_t ALU_ADD  = 4'b0000;
	localparam alu_ctrl_t ALU_SUB  = 4'b0001;
	localparam alu_ctrl_t ALU_SLT  = 4'b0011;
	localparam alu_ctrl_t ALU_SLTU = 4'b0100;
	localparam alu_ctrl_t ALU_XOR  = 4'b0101;
	localparam alu_ctrl_t ALU_OR   = 4'b1000;
	localparam alu_ctrl_t ALU_AND  = 4'b1001;
	// pass src2 through, used for lui
	localparam alu_ctrl_t ALU_PASS = 4'b1010;
	// 5-bit amount shifts
	localparam alu_ctrl_t ALU_SRL  = 4'b1011;
	localparam alu_ctrl_t ALU_SLL  = 4'b1100;
	localparam alu_ctrl_t ALU_SRA  = 4'b1101;

	// operand classes
	// register-register
	localparam op_class_t CLS_REG = 2'd0;
	// register-immediate
	localparam op_class_t CLS_IMM = 2'd1;
	localparam op_class_t CLS_LUI = 2'd2;
	// value 3 is not a legal class and raises an error

endpackage
